// ==== filelist.f ====
logic/exc_pkg.sv
logic/ldst_req_if.sv
logic/exception_sequencer.sv
logic/ldst_port.sv
logic/exception_manager.sv
verification/exception_assertions.sv
verification/exception_checker.sv
verification/tb_exception_manager.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP := tb_exception_manager
FILELIST := filelist.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== verification/tb_exception_manager.sv ====
// Exception manager testbench

module tb_exception_manager;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned SEED = 32'hcc84;
	localparam int MEM_WORDS = 4096;
	localparam int MIN_LAT = 1;
	localparam int MAX_LAT = 6;
	localparam int TIMEOUT = 200;

	logic iCLOCK = 1'b0;
	logic inRESET;
	logic interrupt_lock;
	logic exc_jump;
	logic exc_ib;
	logic irq_req;
	exc_pkg::word_t exc_jump_addr;
	exc_pkg::irq_num_t irq_num;
	exc_pkg::word_t irq_fi0r;
	exc_pkg::word_t sysreg_spr;
	exc_pkg::word_t sysreg_tidr;
	exc_pkg::word_t sysreg_tisr;
	exc_pkg::word_t sysreg_psr;
	exc_pkg::word_t sysreg_ppsr;
	exc_pkg::word_t sysreg_pcr;
	exc_pkg::word_t sysreg_ppcr;
	exc_pkg::word_t sysreg_idtr;
	logic register_lock;
	logic pipeline_stop;
	logic refresh;
	logic pc_set;
	exc_pkg::word_t pc;
	logic ppcr_set;
	exc_pkg::word_t ppcr;
	logic fi0r_set;
	exc_pkg::word_t fi0r;
	logic set_irq_mode;
	logic clr_irq_mode;
	logic irq_ack;
	logic spr_write;
	exc_pkg::word_t spr;
	logic ldst_use;
	exc_pkg::tid_t ldst_tid;
	logic ldst_busy;
	logic ldst_ack;
	exc_pkg::word_t ldst_rdata;
	logic ldst_req;
	logic ldst_rw;
	exc_pkg::word_t ldst_addr;
	exc_pkg::word_t ldst_wdata;
	int errors;
	int tests;

	bit busy_random;
	exc_pkg::word_t mem [0:MEM_WORDS-1];

	exception_manager i_exception_manager (.*);
	exception_checker i_exception_checker (.*);

	always #2 iCLOCK = ~iCLOCK;

	function automatic exc_pkg::word_t mem_fill(input exc_pkg::word_t a);
		return (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
	endfunction

	// Memory pipe with random latency
	always begin
		int lat;
		exc_pkg::word_t rd;
		@(posedge iCLOCK);
		if (inRESET && ldst_req) begin
			lat = MIN_LAT + int'($urandom % (MAX_LAT - MIN_LAT + 1));
			if (ldst_rw)
				mem[ldst_addr[13:2]] = ldst_wdata;
			rd = mem[ldst_addr[13:2]];
			repeat (lat - 1) @(posedge iCLOCK);
			#1 ldst_ack = 1'b1;
			ldst_rdata = rd;
			@(posedge iCLOCK);
			#1 ldst_ack = 1'b0;
		end
	end

	always @(posedge iCLOCK) begin
		#1 ldst_busy = busy_random && ($urandom % 3 == 0);
	end

	task automatic timeout_fail(input string what);
		$display("Timeout while waiting for %s", what);
		$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic wait_output(input bit want_ppcr);
		int n;
		for (n = 0; n < TIMEOUT; n++) begin
			@(posedge iCLOCK);
			if (want_ppcr ? ppcr_set : pc_set)
				break;
		end
		if (n == TIMEOUT)
			timeout_fail(want_ppcr ? "ppcr_set" : "pc_set");
	endtask

	task automatic set_regs(input exc_pkg::word_t psr, input exc_pkg::word_t ppsr, input int tid);
		@(posedge iCLOCK);
		#1 sysreg_psr = psr;
		sysreg_ppsr = ppsr;
		sysreg_tidr = exc_pkg::word_t'(tid);
		sysreg_spr = 32'h8000_0000 | exc_pkg::word_t'(tid);
		sysreg_pcr = 32'h0001_0000 + exc_pkg::word_t'(tid * 16);
		sysreg_ppcr = 32'h0002_0000 + exc_pkg::word_t'(tid * 16);
	endtask

	task automatic run_jump(input exc_pkg::word_t addr, input bit with_irq, input int num);
		@(posedge iCLOCK);
		#1 exc_jump = 1'b1;
		exc_jump_addr = addr;
		irq_req = with_irq;
		irq_num = 7'(num);
		irq_fi0r = 32'hf100_0000 | exc_pkg::word_t'(num);
		@(posedge iCLOCK);
		#1 exc_jump = 1'b0;
		if (with_irq) begin
			wait_output(1'b1);
			#1 irq_req = 1'b0;
		end
		wait_output(1'b0);
	endtask

	task automatic run_irq(input int num, input bit locked);
		@(posedge iCLOCK);
		#1 irq_req = 1'b1;
		interrupt_lock = locked;
		irq_num = 7'(num);
		irq_fi0r = 32'hf100_0000 | exc_pkg::word_t'(num);
		if (locked) begin
			// Held off until the lock drops
			repeat (5) @(posedge iCLOCK);
			#1 interrupt_lock = 1'b0;
		end
		wait_output(1'b1);
		#1 irq_req = 1'b0;
		wait_output(1'b0);
	endtask

	task automatic run_return();
		@(posedge iCLOCK);
		#1 exc_ib = 1'b1;
		@(posedge iCLOCK);
		#1 exc_ib = 1'b0;
		wait_output(1'b0);
	endtask

	initial begin
		void'($urandom(SEED));
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = mem_fill(exc_pkg::word_t'(i) << 2);
		inRESET = 1'b0;
		{interrupt_lock, exc_jump, exc_ib, irq_req, ldst_busy, ldst_ack} = '0;
		{exc_jump_addr, irq_fi0r, sysreg_spr, sysreg_tidr, sysreg_psr} = '0;
		{sysreg_ppsr, sysreg_pcr, sysreg_ppcr, ldst_rdata} = '0;
		irq_num = '0;
		sysreg_tisr = 32'h0000_2000;
		sysreg_idtr = 32'h0000_1000;
		busy_random = 1'b0;
		repeat (10) @(posedge iCLOCK);
		#1 inRESET = 1'b1;
		// Second pass repeats everything under back-pressure
		for (int p = 0; p < 2; p++) begin
			busy_random = (p == 1);
			set_regs(32'h0000_0004, 32'h0000_0000, 1 + p);
			run_jump(32'h0000_4a20 + exc_pkg::word_t'(p * 4), 1'b0, 0);
			run_irq(5 + p, 1'b0);
			set_regs(32'h0000_0064, 32'h0000_0060, 3 + p);
			run_irq(100 + p, 1'b0);
			run_return();
			set_regs(32'h0000_0004, 32'h0000_0000, 5 + p);
			run_return();
			run_jump(32'h0000_7c40, 1'b1, 17 + p);
			set_regs(32'h0000_0064, 32'h0000_0000, 7 + p);
			run_irq(127 - p, 1'b1);
		end
		repeat (5) @(posedge iCLOCK);
		$display("Tests run %0d, errors %0d", tests, errors);
		if (errors == 0 && tests == 14)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== verification/exception_checker.sv ====
// Exception manager checker
// Reference model and comparison of DUT outputs

module exception_checker (
	input logic iCLOCK,
	input logic inRESET,
	input logic interrupt_lock,
	input logic exc_jump,
	input logic exc_ib,
	input logic irq_req,
	input exc_pkg::word_t exc_jump_addr,
	input exc_pkg::irq_num_t irq_num,
	input exc_pkg::word_t irq_fi0r,
	input exc_pkg::word_t sysreg_spr,
	input exc_pkg::word_t sysreg_tidr,
	input exc_pkg::word_t sysreg_tisr,
	input exc_pkg::word_t sysreg_psr,
	input exc_pkg::word_t sysreg_ppsr,
	input exc_pkg::word_t sysreg_pcr,
	input exc_pkg::word_t sysreg_ppcr,
	input exc_pkg::word_t sysreg_idtr,
	input logic register_lock,
	input logic pipeline_stop,
	input logic refresh,
	input logic pc_set,
	input exc_pkg::word_t pc,
	input logic ppcr_set,
	input exc_pkg::word_t ppcr,
	input logic fi0r_set,
	input exc_pkg::word_t fi0r,
	input logic set_irq_mode,
	input logic clr_irq_mode,
	input logic irq_ack,
	input logic spr_write,
	input exc_pkg::word_t spr,
	input logic ldst_use,
	input exc_pkg::tid_t ldst_tid,
	input logic ldst_req,
	input logic ldst_rw,
	input exc_pkg::word_t ldst_addr,
	input exc_pkg::word_t ldst_wdata,
	output int errors,
	output int tests
);

	timeunit 1ns;
	timeprecision 100ps;

	typedef enum {K_JUMP, K_IRQ, K_RET} kind_e;

	kind_e kind;
	string name;
	bit active;
	bit pending;
	bit ppcr_seen;
	bit mark;
	int cyc;
	int start_cyc;
	int mark_cyc;
	int errors_at_start;
	int n_exp;
	int n_seen;
	bit exp_write[4];
	exc_pkg::word_t exp_addr[4];
	exc_pkg::word_t exp_wdata[4];
	exc_pkg::word_t exp_pc;
	exc_pkg::word_t exp_ppcr;
	exc_pkg::word_t exp_fi0r;
	exc_pkg::word_t exp_spr;
	exc_pkg::tid_t exp_tid;
	bit exp_spr_write;
	// Words the DUT has written so far
	exc_pkg::word_t written[exc_pkg::word_t];

	initial begin
		errors = 0;
		tests = 0;
		cyc = 0;
		active = 1'b0;
	end

	function automatic exc_pkg::word_t mem_fill(input exc_pkg::word_t a);
		return (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
	endfunction

	function automatic exc_pkg::word_t mem_value(input exc_pkg::word_t a);
		return written.exists(a) ? written[a] : mem_fill(a);
	endfunction

	function void add_transfer(input bit wr, input exc_pkg::word_t a, input exc_pkg::word_t d);
		exp_write[n_exp] = wr;
		exp_addr[n_exp] = a;
		exp_wdata[n_exp] = d;
		n_exp++;
	endfunction

	// Expected transfers and results of one sequence
	function void predict(input kind_e k, input bit pend, input exc_pkg::word_t jaddr,
		input exc_pkg::irq_num_t num, input exc_pkg::word_t fi0r_in,
		input exc_pkg::word_t spr_in, input exc_pkg::word_t tidr_in,
		input exc_pkg::word_t tisr_in, input exc_pkg::word_t psr_in,
		input exc_pkg::word_t ppsr_in, input exc_pkg::word_t pcr_in,
		input exc_pkg::word_t ppcr_in, input exc_pkg::word_t idtr_in);
		exc_pkg::word_t slot;
		exc_pkg::word_t vec;
		// 256 byte task slot with kernel SPR at 0 and user SPR at 4
		slot = tisr_in + {10'd0, tidr_in[13:0], 8'd0};
		// 8 byte IDT entry with the handler at 4
		vec = idtr_in + {22'd0, num, 3'd0} + 32'd4;
		n_exp = 0;
		exp_spr_write = 1'b0;
		exp_spr = '0;
		exp_tid = tidr_in[13:0];
		exp_fi0r = fi0r_in;
		exp_ppcr = pend ? jaddr : pcr_in;
		case (k)
			K_JUMP: exp_pc = jaddr;
			K_IRQ: begin
				add_transfer(1'b0, vec, '0);
				exp_pc = mem_value(vec);
				if (psr_in[6:5] == 2'd3) begin
					add_transfer(1'b1, slot + 32'd4, spr_in);
					add_transfer(1'b0, slot, '0);
					exp_spr_write = 1'b1;
					exp_spr = mem_value(slot);
				end
			end
			default: begin
				exp_pc = ppcr_in;
				if (ppsr_in[6:5] == 2'd3) begin
					add_transfer(1'b1, slot, spr_in);
					add_transfer(1'b0, slot + 32'd4, '0);
					exp_spr_write = 1'b1;
					exp_spr = mem_value(slot + 32'd4);
				end
			end
		endcase
	endfunction

	function void check_word(input string sig, input exc_pkg::word_t got,
		input exc_pkg::word_t exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %08h expected %08h", sig, got, exp);
		end
	endfunction

	function void check_bit(input string sig, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %0h expected %0h", sig, got, exp);
		end
	endfunction

	function void fail(input string what);
		errors++;
		$display("Error: %s", what);
	endfunction

	// Stall and lock levels
	function void check_levels(input bit busy, input bit ending);
		bit cond;
		cond = irq_req && sysreg_psr[2] && !interrupt_lock && !exc_jump;
		check_bit("ldst_use", ldst_use, busy);
		check_bit("pipeline_stop", pipeline_stop, busy || cond);
		check_bit("register_lock", register_lock, busy || ending || cond);
	endfunction

	function void look_for_start();
		bit irq_en;
		bit go;
		irq_en = irq_req && sysreg_psr[2] && !interrupt_lock;
		go = 1'b1;
		if (pc_set || ppcr_set || ldst_req || refresh || irq_ack || fi0r_set
			|| set_irq_mode || clr_irq_mode || spr_write)
			fail("output activity while the manager is idle");
		check_levels(1'b0, 1'b0);
		if (exc_jump) begin
			kind = irq_en ? K_IRQ : K_JUMP;
			name = irq_en ? "jump with pending interrupt" : "jump";
		end else if (irq_en) begin
			kind = K_IRQ;
			name = sysreg_psr[6:5] == 2'd3 ? "interrupt entry user" : "interrupt entry kernel";
		end else if (exc_ib) begin
			kind = K_RET;
			name = sysreg_ppsr[6:5] == 2'd3 ? "return to user" : "return to kernel";
		end else begin
			go = 1'b0;
		end
		if (go) begin
			pending = exc_jump && irq_en;
			predict(kind, pending, exc_jump_addr, irq_num, irq_fi0r, sysreg_spr,
				sysreg_tidr, sysreg_tisr, sysreg_psr, sysreg_ppsr, sysreg_pcr, sysreg_ppcr,
				sysreg_idtr);
			active = 1'b1;
			ppcr_seen = 1'b0;
			n_seen = 0;
			start_cyc = cyc;
			// Entry marker one cycle later behind a jump
			mark_cyc = cyc + (pending ? 2 : 1);
			errors_at_start = errors;
		end
	endfunction

	function void finish_test();
		check_word("pc", pc, exp_pc);
		check_bit("spr_write", spr_write, exp_spr_write);
		if (exp_spr_write)
			check_word("spr", spr, exp_spr);
		check_word("transfer_count", exc_pkg::word_t'(n_seen), exc_pkg::word_t'(n_exp));
		check_bit("irq_ack", irq_ack, kind == K_IRQ);
		check_bit("fi0r_set", fi0r_set, kind == K_IRQ);
		check_bit("clr_irq_mode", clr_irq_mode, kind == K_RET);
		if (kind == K_IRQ) begin
			check_word("fi0r", fi0r, exp_fi0r);
			if (!ppcr_seen)
				fail("interrupt entry ended without ppcr_set");
		end
		if (kind == K_JUMP && cyc - start_cyc != 2)
			fail("pc_set did not come two cycles after exc_jump");
		tests++;
		$display("Test %0d %s: %s", tests, name, errors == errors_at_start ? "ok" : "failed");
		active = 1'b0;
	endfunction

	always @(posedge iCLOCK) begin
		cyc++;
		if (!inRESET) begin
			active = 1'b0;
		end else if (!active) begin
			look_for_start();
		end else begin
			if (ldst_req) begin
				if (n_seen >= n_exp) begin
					fail("memory transfer beyond the expected ones");
				end else begin
					check_bit("ldst_rw", ldst_rw, exp_write[n_seen]);
					check_word("ldst_addr", ldst_addr, exp_addr[n_seen]);
					if (exp_write[n_seen])
						check_word("ldst_wdata", ldst_wdata, exp_wdata[n_seen]);
				end
				if (ldst_rw)
					written[ldst_addr] = ldst_wdata;
				n_seen++;
			end
			mark = (kind == K_IRQ) && (cyc == mark_cyc);
			check_bit("ppcr_set", ppcr_set, mark);
			check_bit("set_irq_mode", set_irq_mode, mark);
			check_bit("refresh", refresh, mark || (cyc == start_cyc + 1));
			if (ppcr_set) begin
				ppcr_seen = 1'b1;
				check_word("ppcr", ppcr, exp_ppcr);
			end
			check_word("ldst_tid", exc_pkg::word_t'(ldst_tid), exc_pkg::word_t'(exp_tid));
			check_levels(!pc_set, pc_set);
			if (pc_set)
				finish_test();
			else if (irq_ack || fi0r_set || clr_irq_mode || spr_write)
				fail("sequence end pulse without pc_set");
		end
	end

endmodule

// ==== verification/exception_assertions.sv ====
// Load/store and entry pulse assertions

module exception_assertions (
	input logic iCLOCK,
	input logic inRESET,
	input logic ldst_req,
	input logic ldst_busy,
	input logic start,
	input logic done,
	input logic pc_set,
	input logic irq_ack,
	input logic fi0r_set,
	input logic set_irq_mode
);

	timeunit 1ns;
	timeprecision 100ps;

	// Transfer accepted by the port and not yet completed
	logic outstanding;
	// Transfer accepted and not yet issued to memory
	logic waiting;
	// Entry opened by set_irq_mode and not yet acknowledged
	logic entry_open;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			outstanding <= 1'b0;
		end else if (start) begin
			outstanding <= 1'b1;
		end else if (done) begin
			outstanding <= 1'b0;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			waiting <= 1'b0;
		end else if (start) begin
			waiting <= 1'b1;
		end else if (ldst_req) begin
			waiting <= 1'b0;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			entry_open <= 1'b0;
		end else if (set_irq_mode) begin
			entry_open <= 1'b1;
		end else if (irq_ack) begin
			entry_open <= 1'b0;
		end
	end

	req_not_busy: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ldst_req == (waiting && !ldst_busy))
		else $error("ldst_req not given in the first free cycle after start");

	req_one_cycle: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ldst_req |=> !ldst_req)
		else $error("ldst_req held for more than one cycle");

	done_after_start: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		done |-> outstanding)
		else $error("done given without a prior start");

	entry_pulses: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(irq_ack || fi0r_set) |-> (irq_ack && fi0r_set && pc_set && entry_open))
		else $error("irq_ack, fi0r_set and pc_set do not close an open entry");

endmodule

bind exception_manager exception_assertions i_exception_assertions (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.ldst_req(ldst_req),
	.ldst_busy(ldst_busy),
	.start(ldst_if.start),
	.done(ldst_if.done),
	.pc_set(pc_set),
	.irq_ack(irq_ack),
	.fi0r_set(fi0r_set),
	.set_irq_mode(set_irq_mode)
);

// ==== logic/exception_manager.sv ====
// Exception manager top level

module exception_manager (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic interrupt_lock,
	input  logic exc_jump,
	input  exc_pkg::word_t exc_jump_addr,
	input  logic exc_ib,
	input  logic irq_req,
	input  exc_pkg::irq_num_t irq_num,
	input  exc_pkg::word_t irq_fi0r,
	input  exc_pkg::word_t sysreg_spr,
	input  exc_pkg::word_t sysreg_tidr,
	input  exc_pkg::word_t sysreg_tisr,
	input  exc_pkg::word_t sysreg_psr,
	input  exc_pkg::word_t sysreg_ppsr,
	input  exc_pkg::word_t sysreg_pcr,
	input  exc_pkg::word_t sysreg_ppcr,
	input  exc_pkg::word_t sysreg_idtr,
	output logic register_lock,
	output logic pipeline_stop,
	output logic refresh,
	output logic pc_set,
	output exc_pkg::word_t pc,
	output logic ppcr_set,
	output exc_pkg::word_t ppcr,
	output logic fi0r_set,
	output exc_pkg::word_t fi0r,
	output logic set_irq_mode,
	output logic clr_irq_mode,
	output logic irq_ack,
	output logic spr_write,
	output exc_pkg::word_t spr,
	output logic ldst_use,
	output exc_pkg::tid_t ldst_tid,
	input  logic ldst_busy,
	input  logic ldst_ack,
	input  exc_pkg::word_t ldst_rdata,
	output logic ldst_req,
	output logic ldst_rw,
	output exc_pkg::word_t ldst_addr,
	output exc_pkg::word_t ldst_wdata
);

	ldst_req_if ldst_if ();

	exception_sequencer i_exception_sequencer (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.interrupt_lock(interrupt_lock),
		.exc_jump(exc_jump),
		.exc_jump_addr(exc_jump_addr),
		.exc_ib(exc_ib),
		.irq_req(irq_req),
		.irq_num(irq_num),
		.irq_fi0r(irq_fi0r),
		.sysreg_spr(sysreg_spr),
		.sysreg_tidr(sysreg_tidr),
		.sysreg_tisr(sysreg_tisr),
		.sysreg_psr(sysreg_psr),
		.sysreg_ppsr(sysreg_ppsr),
		.sysreg_pcr(sysreg_pcr),
		.sysreg_ppcr(sysreg_ppcr),
		.sysreg_idtr(sysreg_idtr),
		.register_lock(register_lock),
		.pipeline_stop(pipeline_stop),
		.refresh(refresh),
		.pc_set(pc_set),
		.pc(pc),
		.ppcr_set(ppcr_set),
		.ppcr(ppcr),
		.fi0r_set(fi0r_set),
		.fi0r(fi0r),
		.set_irq_mode(set_irq_mode),
		.clr_irq_mode(clr_irq_mode),
		.irq_ack(irq_ack),
		.spr_write(spr_write),
		.spr(spr),
		.ldst_use(ldst_use),
		.ldst_tid(ldst_tid),
		.mem(ldst_if.sequencer)
	);

	// One transfer in flight at a time
	ldst_port i_ldst_port (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.req(ldst_if.port),
		.ldst_busy(ldst_busy),
		.ldst_ack(ldst_ack),
		.ldst_rdata(ldst_rdata),
		.ldst_req(ldst_req),
		.ldst_rw(ldst_rw),
		.ldst_addr(ldst_addr),
		.ldst_wdata(ldst_wdata)
	);

endmodule

// ==== logic/ldst_port.sv ====
// Single-word load/store port
// Toward the core memory pipe

module ldst_port (
	input  logic iCLOCK,
	input  logic inRESET,
	ldst_req_if.port req,
	input  logic ldst_busy,
	input  logic ldst_ack,
	input  exc_pkg::word_t ldst_rdata,
	output logic ldst_req,
	output logic ldst_rw,
	output exc_pkg::word_t ldst_addr,
	output exc_pkg::word_t ldst_wdata
);

	typedef enum logic [1:0] {
		PORT_IDLE,
		PORT_ISSUE,
		PORT_WAIT_ACK
	} port_state_e;

	port_state_e state;
	logic done_q;

	// Held transfer
	exc_pkg::ldst_op_e op_q;
	exc_pkg::word_t addr_q;
	exc_pkg::word_t wdata_q;
	exc_pkg::word_t rdata_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= PORT_IDLE;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				PORT_IDLE: begin
					if (req.start)
						state <= PORT_ISSUE;
				end
				PORT_ISSUE: begin
					// Request goes out in this cycle once busy is low
					if (!ldst_busy)
						state <= PORT_WAIT_ACK;
				end
				PORT_WAIT_ACK: begin
					if (ldst_ack) begin
						done_q <= 1'b1;
						state <= PORT_IDLE;
					end
				end
				default: begin
					state <= PORT_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (state == PORT_IDLE && req.start) begin
			op_q <= req.op;
			addr_q <= req.addr;
			wdata_q <= req.wdata;
		end
		// Read data arrives with the ack
		if (state == PORT_WAIT_ACK && ldst_ack)
			rdata_q <= ldst_rdata;
	end

	assign ldst_req = (state == PORT_ISSUE) && !ldst_busy;
	assign ldst_rw = (op_q == exc_pkg::LDST_WRITE);
	assign ldst_addr = addr_q;
	assign ldst_wdata = wdata_q;

	assign req.done = done_q;
	assign req.rdata = rdata_q;

endmodule

// ==== logic/exception_sequencer.sv ====
// Exception sequencer
// Jump, interrupt entry and interrupt return control

module exception_sequencer (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic interrupt_lock,
	input  logic exc_jump,
	input  exc_pkg::word_t exc_jump_addr,
	input  logic exc_ib,
	input  logic irq_req,
	input  exc_pkg::irq_num_t irq_num,
	input  exc_pkg::word_t irq_fi0r,
	input  exc_pkg::word_t sysreg_spr,
	input  exc_pkg::word_t sysreg_tidr,
	input  exc_pkg::word_t sysreg_tisr,
	input  exc_pkg::word_t sysreg_psr,
	input  exc_pkg::word_t sysreg_ppsr,
	input  exc_pkg::word_t sysreg_pcr,
	input  exc_pkg::word_t sysreg_ppcr,
	input  exc_pkg::word_t sysreg_idtr,
	output logic register_lock,
	output logic pipeline_stop,
	output logic refresh,
	output logic pc_set,
	output exc_pkg::word_t pc,
	output logic ppcr_set,
	output exc_pkg::word_t ppcr,
	output logic fi0r_set,
	output exc_pkg::word_t fi0r,
	output logic set_irq_mode,
	output logic clr_irq_mode,
	output logic irq_ack,
	output logic spr_write,
	output exc_pkg::word_t spr,
	output logic ldst_use,
	output exc_pkg::tid_t ldst_tid,
	ldst_req_if.sequencer mem
);

	exc_pkg::main_state_e main_state;
	exc_pkg::sub_state_e sub_state;

	// Register snapshot taken while idle
	exc_pkg::word_t spr_q;
	exc_pkg::word_t tidr_q;
	exc_pkg::word_t tisr_q;
	exc_pkg::word_t psr_q;
	exc_pkg::word_t idtr_q;

	exc_pkg::word_t pc_q;
	exc_pkg::word_t ppcr_q;
	exc_pkg::word_t fi0r_q;
	exc_pkg::word_t spr_new_q;
	exc_pkg::irq_num_t irq_num_q;
	logic irq_pending_q;
	logic spr_swap_q;

	logic refresh_q;
	logic pc_set_q;
	logic ppcr_set_q;
	logic fi0r_set_q;
	logic set_irq_q;
	logic clr_irq_q;
	logic irq_ack_q;
	logic spr_write_q;

	logic start_q;
	exc_pkg::ldst_op_e op_q;
	exc_pkg::word_t addr_q;
	exc_pkg::word_t wdata_q;

	logic irq_enabled;
	logic irq_cond;
	exc_pkg::word_t vector_addr;
	exc_pkg::word_t slot_base;
	exc_pkg::word_t kspr_addr;
	exc_pkg::word_t uspr_addr;
	exc_pkg::word_t save_addr;
	exc_pkg::word_t load_addr;

	assign irq_enabled = irq_req && sysreg_psr[exc_pkg::PSR_IRQ_ENABLE_BIT] && !interrupt_lock;
	// A jump in the same cycle takes priority
	assign irq_cond = irq_enabled && !exc_jump;

	assign vector_addr = idtr_q + (exc_pkg::word_t'(irq_num_q) << exc_pkg::IDT_ENTRY_SHIFT)
		+ exc_pkg::IDT_HANDLER_OFFSET;
	assign slot_base = tisr_q + (exc_pkg::word_t'(tidr_q[13:0]) << exc_pkg::TST_SLOT_SHIFT);
	assign kspr_addr = slot_base + exc_pkg::TST_KSPR_OFFSET;
	assign uspr_addr = slot_base + exc_pkg::TST_USPR_OFFSET;

	// Entry saves the user SPR and loads the kernel one, return does the opposite
	assign save_addr = (main_state == exc_pkg::ST_IRQ_RET) ? kspr_addr : uspr_addr;
	assign load_addr = (main_state == exc_pkg::ST_IRQ_RET) ? uspr_addr : kspr_addr;

	always_ff @(posedge iCLOCK) begin
		if (main_state == exc_pkg::ST_IDLE) begin
			spr_q <= sysreg_spr;
			tidr_q <= sysreg_tidr;
			tisr_q <= sysreg_tisr;
			psr_q <= sysreg_psr;
			idtr_q <= sysreg_idtr;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			main_state <= exc_pkg::ST_IDLE;
			sub_state <= exc_pkg::SUB_VECTOR;
			pc_q <= '0;
			ppcr_q <= '0;
			fi0r_q <= '0;
			spr_new_q <= '0;
			irq_num_q <= '0;
			irq_pending_q <= 1'b0;
			spr_swap_q <= 1'b0;
			refresh_q <= 1'b0;
			pc_set_q <= 1'b0;
			ppcr_set_q <= 1'b0;
			fi0r_set_q <= 1'b0;
			set_irq_q <= 1'b0;
			clr_irq_q <= 1'b0;
			irq_ack_q <= 1'b0;
			spr_write_q <= 1'b0;
			start_q <= 1'b0;
			op_q <= exc_pkg::LDST_READ;
			addr_q <= '0;
			wdata_q <= '0;
		end else begin
			// Pulses last one cycle unless set below
			refresh_q <= 1'b0;
			pc_set_q <= 1'b0;
			ppcr_set_q <= 1'b0;
			fi0r_set_q <= 1'b0;
			set_irq_q <= 1'b0;
			clr_irq_q <= 1'b0;
			irq_ack_q <= 1'b0;
			spr_write_q <= 1'b0;
			start_q <= 1'b0;
			case (main_state)
				exc_pkg::ST_IDLE: begin
					spr_swap_q <= 1'b0;
					if (exc_jump) begin
						main_state <= exc_pkg::ST_JUMP;
						refresh_q <= 1'b1;
						pc_q <= exc_jump_addr;
						// Interrupt waiting behind the jump
						irq_pending_q <= irq_enabled;
						irq_num_q <= irq_num;
						fi0r_q <= irq_fi0r;
					end else if (irq_cond) begin
						main_state <= exc_pkg::ST_IRQ_SET;
						sub_state <= exc_pkg::SUB_VECTOR;
						refresh_q <= 1'b1;
						ppcr_set_q <= 1'b1;
						ppcr_q <= sysreg_pcr;
						set_irq_q <= 1'b1;
						irq_num_q <= irq_num;
						fi0r_q <= irq_fi0r;
					end else if (exc_ib) begin
						main_state <= exc_pkg::ST_IRQ_RET;
						refresh_q <= 1'b1;
						pc_q <= sysreg_ppcr;
						if (sysreg_ppsr[exc_pkg::CORE_MODE_LSB +: 2] == exc_pkg::MODE_USER)
							sub_state <= exc_pkg::SUB_SPR_SAVE;
						else
							sub_state <= exc_pkg::SUB_FINISH;
					end
				end
				exc_pkg::ST_JUMP: begin
					irq_pending_q <= 1'b0;
					if (irq_pending_q) begin
						// Return address becomes the jump target
						main_state <= exc_pkg::ST_IRQ_SET;
						sub_state <= exc_pkg::SUB_VECTOR;
						refresh_q <= 1'b1;
						ppcr_set_q <= 1'b1;
						ppcr_q <= pc_q;
						set_irq_q <= 1'b1;
					end else begin
						main_state <= exc_pkg::ST_IDLE;
						pc_set_q <= 1'b1;
					end
				end
				exc_pkg::ST_IRQ_SET, exc_pkg::ST_IRQ_RET: begin
					case (sub_state)
						exc_pkg::SUB_VECTOR: begin
							start_q <= 1'b1;
							op_q <= exc_pkg::LDST_READ;
							addr_q <= vector_addr;
							sub_state <= exc_pkg::SUB_VECTOR_WAIT;
						end
						exc_pkg::SUB_VECTOR_WAIT: begin
							if (mem.done) begin
								pc_q <= mem.rdata;
								if (psr_q[exc_pkg::CORE_MODE_LSB +: 2] == exc_pkg::MODE_USER)
									sub_state <= exc_pkg::SUB_SPR_SAVE;
								else
									sub_state <= exc_pkg::SUB_FINISH;
							end
						end
						exc_pkg::SUB_SPR_SAVE: begin
							start_q <= 1'b1;
							op_q <= exc_pkg::LDST_WRITE;
							addr_q <= save_addr;
							wdata_q <= spr_q;
							sub_state <= exc_pkg::SUB_SPR_SAVE_WAIT;
						end
						exc_pkg::SUB_SPR_SAVE_WAIT: begin
							if (mem.done)
								sub_state <= exc_pkg::SUB_SPR_LOAD;
						end
						exc_pkg::SUB_SPR_LOAD: begin
							start_q <= 1'b1;
							op_q <= exc_pkg::LDST_READ;
							addr_q <= load_addr;
							sub_state <= exc_pkg::SUB_SPR_LOAD_WAIT;
						end
						exc_pkg::SUB_SPR_LOAD_WAIT: begin
							if (mem.done) begin
								spr_new_q <= mem.rdata;
								spr_swap_q <= 1'b1;
								sub_state <= exc_pkg::SUB_FINISH;
							end
						end
						default: begin
							// Redirect and leave
							main_state <= exc_pkg::ST_IDLE;
							sub_state <= exc_pkg::SUB_VECTOR;
							pc_set_q <= 1'b1;
							spr_write_q <= spr_swap_q;
							if (main_state == exc_pkg::ST_IRQ_SET) begin
								fi0r_set_q <= 1'b1;
								irq_ack_q <= 1'b1;
							end else begin
								clr_irq_q <= 1'b1;
							end
						end
					endcase
				end
				default: begin
					main_state <= exc_pkg::ST_IDLE;
				end
			endcase
		end
	end

	assign pipeline_stop = (main_state != exc_pkg::ST_IDLE) || irq_cond;
	assign register_lock = pipeline_stop || refresh_q || pc_set_q;
	assign refresh = refresh_q;
	assign pc_set = pc_set_q;
	assign pc = pc_q;
	assign ppcr_set = ppcr_set_q;
	assign ppcr = ppcr_q;
	assign fi0r_set = fi0r_set_q;
	assign fi0r = fi0r_q;
	assign set_irq_mode = set_irq_q;
	assign clr_irq_mode = clr_irq_q;
	assign irq_ack = irq_ack_q;
	assign spr_write = spr_write_q;
	assign spr = spr_new_q;
	assign ldst_use = (main_state != exc_pkg::ST_IDLE);
	assign ldst_tid = exc_pkg::tid_t'(tidr_q[13:0]);

	assign mem.start = start_q;
	assign mem.op = op_q;
	assign mem.addr = addr_q;
	assign mem.wdata = wdata_q;

endmodule

// ==== logic/ldst_req_if.sv ====
// Load/store transfer request
// Sequencer to single-word port

interface ldst_req_if;

	// One-cycle request while the port is idle
	logic start;
	exc_pkg::ldst_op_e op;
	exc_pkg::word_t addr;
	exc_pkg::word_t wdata;

	// One-cycle completion with rdata held afterwards
	logic done;
	exc_pkg::word_t rdata;

	modport sequencer (
		output start,
		output op,
		output addr,
		output wdata,
		input  done,
		input  rdata
	);

	modport port (
		input  start,
		input  op,
		input  addr,
		input  wdata,
		output done,
		output rdata
	);

endinterface

// ==== logic/exc_pkg.sv ====
// Exception manager shared types
// Widths, memory layout and state encodings

package exc_pkg;

	typedef logic [31:0] word_t;
	typedef logic [6:0]  irq_num_t;
	typedef logic [13:0] tid_t;

	// Core mode field in PSR and PPSR
	typedef enum logic [1:0] {
		MODE_KERNEL = 2'd0,
		MODE_USER   = 2'd3
	} core_mode_t;

	localparam int unsigned CORE_MODE_LSB = 5;
	localparam int unsigned PSR_IRQ_ENABLE_BIT = 2;

	// Interrupt descriptor table of 8 byte entries
	localparam int unsigned IDT_ENTRY_SHIFT = 3;
	localparam word_t IDT_HANDLER_OFFSET = 32'd4;

	// Task state table with one 256 byte slot per task
	localparam int unsigned TST_SLOT_SHIFT = 8;
	localparam word_t TST_KSPR_OFFSET = 32'd0;
	localparam word_t TST_USPR_OFFSET = 32'd4;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_JUMP,
		ST_IRQ_SET,
		ST_IRQ_RET
	} main_state_e;

	// Sub steps shared by interrupt entry and return
	typedef enum logic [2:0] {
		SUB_VECTOR,
		SUB_VECTOR_WAIT,
		SUB_SPR_SAVE,
		SUB_SPR_SAVE_WAIT,
		SUB_SPR_LOAD,
		SUB_SPR_LOAD_WAIT,
		SUB_FINISH
	} sub_state_e;

	typedef enum logic {
		LDST_READ,
		LDST_WRITE
	} ldst_op_e;

endpackage
